// ==== common/mips_isa_pkg.sv ====
package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [15:0] imm_t;

  // Primary opcodes, standard MIPS values
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0a;
  localparam opcode_t OP_SLTIU = 6'h0b;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_XORI  = 6'h0e;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LB    = 6'h20;
  localparam opcode_t OP_LH    = 6'h21;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_LBU   = 6'h24;
  localparam opcode_t OP_LHU   = 6'h25;
  localparam opcode_t OP_SB    = 6'h28;
  localparam opcode_t OP_SH    = 6'h29;
  localparam opcode_t OP_SW    = 6'h2b;

  // Function field of R-type words
  localparam funct_t FN_SLL   = 6'h00;
  localparam funct_t FN_SRL   = 6'h02;
  localparam funct_t FN_SRA   = 6'h03;
  localparam funct_t FN_SLLV  = 6'h04;
  localparam funct_t FN_SRLV  = 6'h06;
  localparam funct_t FN_SRAV  = 6'h07;
  localparam funct_t FN_MULT  = 6'h18;
  localparam funct_t FN_MULTU = 6'h19;
  localparam funct_t FN_DIV   = 6'h1a;
  localparam funct_t FN_DIVU  = 6'h1b;
  localparam funct_t FN_ADDU  = 6'h21;
  localparam funct_t FN_SUBU  = 6'h23;
  localparam funct_t FN_AND   = 6'h24;
  localparam funct_t FN_OR    = 6'h25;
  localparam funct_t FN_XOR   = 6'h26;
  localparam funct_t FN_SLT   = 6'h2a;
  localparam funct_t FN_SLTU  = 6'h2b;

endpackage

// ==== common/alu_op_pkg.sv ====
package alu_op_pkg;

  // Micro-ops seen by the execute stage
  typedef enum logic [4:0] {
    ALU_NONE,   // Unknown encoding
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI,
    ALU_BEQ,
    ALU_BNE,
    ALU_MULT,
    ALU_MULTU,
    ALU_DIV,
    ALU_DIVU
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_B_RT,
    SRC_B_SIMM,  // Sign-extended immediate
    SRC_B_ZIMM   // Zero-extended immediate
  } src_b_e;

  typedef enum logic {
    SHIFT_SHAMT,
    SHIFT_RS     // Variable shift, rs bits 4..0
  } shift_src_e;

  typedef logic [63:0] dword_t;
  typedef logic [5:0]  step_cnt_t;

  localparam step_cnt_t MULDIV_STEPS = 6'd32;  // One quotient bit per step

endpackage

// ==== decode/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  mips_isa_pkg::instr_t   instr,
  input  mips_isa_pkg::word_t    rs_value,
  input  mips_isa_pkg::word_t    rt_value,
  input  logic                   dec_ready,
  output logic                   in_ready,
  output logic                   dec_valid,
  output alu_op_pkg::alu_op_e    op,
  output alu_op_pkg::src_b_e     src_b_sel,
  output alu_op_pkg::shift_src_e shift_sel,
  output mips_isa_pkg::shamt_t   shamt,
  output mips_isa_pkg::word_t    imm_ext,
  output mips_isa_pkg::word_t    dec_rs,
  output mips_isa_pkg::word_t    dec_rt
);

  mips_isa_pkg::instr_t  instr_q;
  mips_isa_pkg::opcode_t opcode;
  mips_isa_pkg::funct_t  funct;
  mips_isa_pkg::imm_t    imm;

  assign in_ready = !dec_valid || dec_ready;  // Empty or handing over now

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dec_valid <= 1'b0;
    end
    else if (in_valid && in_ready)
    begin
      dec_valid <= 1'b1;
    end
    else if (dec_ready)
    begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      instr_q <= instr;
      dec_rs  <= rs_value;
      dec_rt  <= rt_value;
    end
  end

  assign opcode = instr_q[31:26];
  assign shamt  = instr_q[10:6];
  assign funct  = instr_q[5:0];
  assign imm    = instr_q[15:0];

  always_comb
  begin
    op        = alu_op_pkg::ALU_NONE;
    src_b_sel = alu_op_pkg::SRC_B_RT;
    shift_sel = alu_op_pkg::SHIFT_SHAMT;
    case (opcode)
      mips_isa_pkg::OP_RTYPE:
      begin
        if (funct inside {mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV, mips_isa_pkg::FN_SRAV})
        begin
          shift_sel = alu_op_pkg::SHIFT_RS;
        end
        case (funct)
          mips_isa_pkg::FN_ADDU:  op = alu_op_pkg::ALU_ADD;
          mips_isa_pkg::FN_SUBU:  op = alu_op_pkg::ALU_SUB;
          mips_isa_pkg::FN_AND:   op = alu_op_pkg::ALU_AND;
          mips_isa_pkg::FN_OR:    op = alu_op_pkg::ALU_OR;
          mips_isa_pkg::FN_XOR:   op = alu_op_pkg::ALU_XOR;
          mips_isa_pkg::FN_SLL,
          mips_isa_pkg::FN_SLLV:  op = alu_op_pkg::ALU_SLL;
          mips_isa_pkg::FN_SRL,
          mips_isa_pkg::FN_SRLV:  op = alu_op_pkg::ALU_SRL;
          mips_isa_pkg::FN_SRA,
          mips_isa_pkg::FN_SRAV:  op = alu_op_pkg::ALU_SRA;
          mips_isa_pkg::FN_SLT:   op = alu_op_pkg::ALU_SLT;
          mips_isa_pkg::FN_SLTU:  op = alu_op_pkg::ALU_SLTU;
          mips_isa_pkg::FN_MULT:  op = alu_op_pkg::ALU_MULT;
          mips_isa_pkg::FN_MULTU: op = alu_op_pkg::ALU_MULTU;
          mips_isa_pkg::FN_DIV:   op = alu_op_pkg::ALU_DIV;
          mips_isa_pkg::FN_DIVU:  op = alu_op_pkg::ALU_DIVU;
          default:                op = alu_op_pkg::ALU_NONE;
        endcase
      end
      mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH,
      mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
      mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW:
      begin
        op        = alu_op_pkg::ALU_ADD;  // Address add for loads and stores
        src_b_sel = alu_op_pkg::SRC_B_SIMM;
      end
      mips_isa_pkg::OP_SLTI:
      begin
        op        = alu_op_pkg::ALU_SLT;
        src_b_sel = alu_op_pkg::SRC_B_SIMM;
      end
      mips_isa_pkg::OP_SLTIU:
      begin
        op        = alu_op_pkg::ALU_SLTU;
        src_b_sel = alu_op_pkg::SRC_B_SIMM;  // Sign-extended, compared unsigned
      end
      mips_isa_pkg::OP_ANDI:
      begin
        op        = alu_op_pkg::ALU_AND;
        src_b_sel = alu_op_pkg::SRC_B_ZIMM;
      end
      mips_isa_pkg::OP_ORI:
      begin
        op        = alu_op_pkg::ALU_OR;
        src_b_sel = alu_op_pkg::SRC_B_ZIMM;
      end
      mips_isa_pkg::OP_XORI:
      begin
        op        = alu_op_pkg::ALU_XOR;
        src_b_sel = alu_op_pkg::SRC_B_ZIMM;
      end
      mips_isa_pkg::OP_LUI:
      begin
        op        = alu_op_pkg::ALU_LUI;
        src_b_sel = alu_op_pkg::SRC_B_ZIMM;
      end
      mips_isa_pkg::OP_BEQ: op = alu_op_pkg::ALU_BEQ;
      mips_isa_pkg::OP_BNE: op = alu_op_pkg::ALU_BNE;
      default:              op = alu_op_pkg::ALU_NONE;
    endcase
  end

  assign imm_ext = (src_b_sel == alu_op_pkg::SRC_B_ZIMM) ? {16'h0000, imm}
                                                        : {{16{imm[15]}}, imm};

endmodule

// ==== execute/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                md_start,
  input  alu_op_pkg::alu_op_e md_op,
  input  mips_isa_pkg::word_t md_a,
  input  mips_isa_pkg::word_t md_b,
  output logic                md_done,
  output mips_isa_pkg::word_t md_hi,
  output mips_isa_pkg::word_t md_lo
);

  typedef enum logic [1:0] {
    IDLE,
    MUL,   // Product already registered
    DIV,
    DONE
  } md_state_e;

  md_state_e             state;
  logic                  is_mul;
  logic                  is_signed;
  logic                  a_neg;
  logic                  b_neg;
  mips_isa_pkg::word_t   a_mag;
  mips_isa_pkg::word_t   b_mag;
  alu_op_pkg::dword_t    prod_a;
  alu_op_pkg::dword_t    prod_b;
  alu_op_pkg::dword_t    mul_prod;
  mips_isa_pkg::word_t   rem_q;
  mips_isa_pkg::word_t   quo_q;   // Dividend bits shift out, quotient bits shift in
  mips_isa_pkg::word_t   dvs_q;
  logic                  q_neg_q;
  logic                  r_neg_q;
  alu_op_pkg::step_cnt_t cnt_q;
  logic [32:0]           trial;
  logic [32:0]           diff;
  mips_isa_pkg::word_t   rem_next;
  mips_isa_pkg::word_t   quo_next;
  logic                  last_step;

  assign is_mul    = (md_op == alu_op_pkg::ALU_MULT) || (md_op == alu_op_pkg::ALU_MULTU);
  assign is_signed = (md_op == alu_op_pkg::ALU_MULT) || (md_op == alu_op_pkg::ALU_DIV);
  assign a_neg     = is_signed && md_a[31];
  assign b_neg     = is_signed && md_b[31];
  assign a_mag     = a_neg ? -md_a : md_a;
  assign b_mag     = b_neg ? -md_b : md_b;

  assign prod_a   = {{32{a_neg}}, md_a};  // Low 64 bits right for both signednesses
  assign prod_b   = {{32{b_neg}}, md_b};
  assign mul_prod = prod_a * prod_b;

  // One restoring step
  assign trial     = {rem_q, quo_q[31]};
  assign diff      = trial - {1'b0, dvs_q};
  assign rem_next  = diff[32] ? trial[31:0] : diff[31:0];
  assign quo_next  = {quo_q[30:0], !diff[32]};
  assign last_step = (cnt_q == alu_op_pkg::MULDIV_STEPS - 6'd1);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= IDLE;
      cnt_q <= '0;
    end
    else if (md_start)
    begin
      cnt_q <= '0;
      state <= is_mul ? MUL : DIV;
    end
    else
    begin
      case (state)
        DIV:
        begin
          cnt_q <= cnt_q + 6'd1;
          if (last_step)
          begin
            state <= DONE;
          end
        end
        MUL, DONE: state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (md_start)
    begin
      if (is_mul)
      begin
        md_hi <= mul_prod[63:32];
        md_lo <= mul_prod[31:0];
      end
      rem_q   <= '0;
      quo_q   <= a_mag;
      dvs_q   <= b_mag;
      q_neg_q <= (a_neg ^ b_neg) && (md_b != '0);  // Zero divisor keeps all ones
      r_neg_q <= a_neg;                            // Remainder follows dividend
    end
    else if (state == DIV)
    begin
      rem_q <= rem_next;
      quo_q <= quo_next;
      if (last_step)
      begin
        md_hi <= r_neg_q ? -rem_next : rem_next;
        md_lo <= q_neg_q ? -quo_next : quo_next;
      end
    end
  end

  assign md_done = (state == MUL) || (state == DONE);

endmodule

// ==== execute/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dec_valid,
  input  alu_op_pkg::alu_op_e    op,
  input  alu_op_pkg::src_b_e     src_b_sel,
  input  alu_op_pkg::shift_src_e shift_sel,
  input  mips_isa_pkg::shamt_t   shamt,
  input  mips_isa_pkg::word_t    imm_ext,
  input  mips_isa_pkg::word_t    dec_rs,
  input  mips_isa_pkg::word_t    dec_rt,
  input  logic                   ex_ready,
  output logic                   dec_ready,
  output logic                   ex_valid,
  output mips_isa_pkg::word_t    ex_result,
  output logic                   ex_branch,
  output logic                   ex_illegal,
  output logic                   ex_hilo_we,
  output mips_isa_pkg::word_t    ex_hi,
  output mips_isa_pkg::word_t    ex_lo
);

  mips_isa_pkg::word_t  op_b;
  mips_isa_pkg::shamt_t sh_amt;
  logic                 is_md;
  logic                 md_start;
  logic                 md_done;
  logic                 started_q;  // Mul/div already launched for this instruction
  logic                 done_q;     // Catches the md_done pulse under back-pressure
  logic                 md_ok;

  assign op_b   = (src_b_sel == alu_op_pkg::SRC_B_RT) ? dec_rt : imm_ext;
  assign sh_amt = (shift_sel == alu_op_pkg::SHIFT_RS) ? dec_rs[4:0] : shamt;

  assign is_md = op inside {alu_op_pkg::ALU_MULT, alu_op_pkg::ALU_MULTU,
                            alu_op_pkg::ALU_DIV, alu_op_pkg::ALU_DIVU};

  assign md_start  = dec_valid && is_md && !started_q;
  assign md_ok     = !is_md || (started_q && (md_done || done_q));
  assign ex_valid  = dec_valid && md_ok;
  assign dec_ready = ex_ready && md_ok;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      started_q <= 1'b0;
      done_q    <= 1'b0;
    end
    else if (ex_valid && ex_ready)
    begin
      started_q <= 1'b0;  // Ready for the next instruction
      done_q    <= 1'b0;
    end
    else
    begin
      if (md_start)
      begin
        started_q <= 1'b1;
      end
      if (md_done)
      begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb
  begin
    ex_result = '0;
    ex_branch = 1'b0;
    case (op)
      alu_op_pkg::ALU_ADD:  ex_result = dec_rs + op_b;
      alu_op_pkg::ALU_SUB:  ex_result = dec_rs - op_b;
      alu_op_pkg::ALU_AND:  ex_result = dec_rs & op_b;
      alu_op_pkg::ALU_OR:   ex_result = dec_rs | op_b;
      alu_op_pkg::ALU_XOR:  ex_result = dec_rs ^ op_b;
      alu_op_pkg::ALU_SLL:  ex_result = dec_rt << sh_amt;
      alu_op_pkg::ALU_SRL:  ex_result = dec_rt >> sh_amt;
      alu_op_pkg::ALU_SRA:  ex_result = $signed(dec_rt) >>> sh_amt;  // Sign fill
      alu_op_pkg::ALU_SLT:  ex_result = {31'b0, ($signed(dec_rs) < $signed(op_b))};
      alu_op_pkg::ALU_SLTU: ex_result = {31'b0, (dec_rs < op_b)};
      alu_op_pkg::ALU_LUI:  ex_result = {op_b[15:0], 16'h0000};
      alu_op_pkg::ALU_BEQ:
      begin
        ex_result = dec_rs - dec_rt;
        ex_branch = (dec_rs == dec_rt);
      end
      alu_op_pkg::ALU_BNE:
      begin
        ex_result = dec_rs - dec_rt;
        ex_branch = (dec_rs != dec_rt);
      end
      default:              ex_result = '0;  // Mul/div and unknown
    endcase
  end

  assign ex_illegal = (op == alu_op_pkg::ALU_NONE);
  assign ex_hilo_we = is_md;

  muldiv_unit u_muldiv (
    .clk      (clk),
    .reset    (reset),
    .md_start (md_start),
    .md_op    (op),
    .md_a     (dec_rs),
    .md_b     (dec_rt),
    .md_done  (md_done),
    .md_hi    (ex_hi),
    .md_lo    (ex_lo)
  );

endmodule

// ==== logic/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                ex_valid,
  input  mips_isa_pkg::word_t ex_result,
  input  logic                ex_branch,
  input  logic                ex_illegal,
  input  logic                ex_hilo_we,
  input  mips_isa_pkg::word_t ex_hi,
  input  mips_isa_pkg::word_t ex_lo,
  input  logic                out_ready,
  output logic                ex_ready,
  output logic                out_valid,
  output mips_isa_pkg::word_t result,
  output logic                branch_taken,
  output logic                illegal,
  output mips_isa_pkg::word_t hi,
  output mips_isa_pkg::word_t lo
);

  logic load;

  assign ex_ready = !out_valid || out_ready;  // Free or draining this cycle
  assign load     = ex_valid && ex_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (load)
    begin
      out_valid <= 1'b1;
    end
    else if (out_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      result       <= ex_result;
      branch_taken <= ex_branch;
      illegal      <= ex_illegal;
    end
  end

  // Architectural HI/LO
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (load && ex_hilo_we)
    begin
      hi <= ex_hi;
      lo <= ex_lo;
    end
  end

endmodule

// ==== logic/mips_exec_top.sv ====
`timescale 1ns/1ps

module mips_exec_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  mips_isa_pkg::instr_t instr,
  input  mips_isa_pkg::word_t  rs_value,
  input  mips_isa_pkg::word_t  rt_value,
  output logic                 out_valid,
  input  logic                 out_ready,
  output mips_isa_pkg::word_t  result,
  output logic                 branch_taken,
  output logic                 illegal,
  output mips_isa_pkg::word_t  hi,
  output mips_isa_pkg::word_t  lo
);

  logic                   dec_valid;
  logic                   dec_ready;
  alu_op_pkg::alu_op_e    op;
  alu_op_pkg::src_b_e     src_b_sel;
  alu_op_pkg::shift_src_e shift_sel;
  mips_isa_pkg::shamt_t   shamt;
  mips_isa_pkg::word_t    imm_ext;
  mips_isa_pkg::word_t    dec_rs;
  mips_isa_pkg::word_t    dec_rt;
  logic                   ex_valid;
  logic                   ex_ready;
  mips_isa_pkg::word_t    ex_result;
  logic                   ex_branch;
  logic                   ex_illegal;
  logic                   ex_hilo_we;
  mips_isa_pkg::word_t    ex_hi;
  mips_isa_pkg::word_t    ex_lo;

  instr_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .instr     (instr),
    .rs_value  (rs_value),
    .rt_value  (rt_value),
    .dec_ready (dec_ready),
    .in_ready  (in_ready),
    .dec_valid (dec_valid),
    .op        (op),
    .src_b_sel (src_b_sel),
    .shift_sel (shift_sel),
    .shamt     (shamt),
    .imm_ext   (imm_ext),
    .dec_rs    (dec_rs),
    .dec_rt    (dec_rt)
  );

  alu_execute u_execute (
    .clk        (clk),
    .reset      (reset),
    .dec_valid  (dec_valid),
    .op         (op),
    .src_b_sel  (src_b_sel),
    .shift_sel  (shift_sel),
    .shamt      (shamt),
    .imm_ext    (imm_ext),
    .dec_rs     (dec_rs),
    .dec_rt     (dec_rt),
    .ex_ready   (ex_ready),
    .dec_ready  (dec_ready),
    .ex_valid   (ex_valid),
    .ex_result  (ex_result),
    .ex_branch  (ex_branch),
    .ex_illegal (ex_illegal),
    .ex_hilo_we (ex_hilo_we),
    .ex_hi      (ex_hi),
    .ex_lo      (ex_lo)
  );

  result_stage u_result (
    .clk          (clk),
    .reset        (reset),
    .ex_valid     (ex_valid),
    .ex_result    (ex_result),
    .ex_branch    (ex_branch),
    .ex_illegal   (ex_illegal),
    .ex_hilo_we   (ex_hilo_we),
    .ex_hi        (ex_hi),
    .ex_lo        (ex_lo),
    .out_ready    (out_ready),
    .ex_ready     (ex_ready),
    .out_valid    (out_valid),
    .result       (result),
    .branch_taken (branch_taken),
    .illegal      (illegal),
    .hi           (hi),
    .lo           (lo)
  );

endmodule

// ==== sim/mips_exec_chk.sv ====
`timescale 1ns/1ps

module mips_exec_chk (
  input  logic                clk,
  input  logic                reset,
  input  logic                ex_valid,
  input  logic                ex_ready,
  input  mips_isa_pkg::word_t ex_result,
  input  logic                ex_branch,
  input  logic                ex_illegal,
  input  mips_isa_pkg::word_t ex_hi,
  input  mips_isa_pkg::word_t ex_lo,
  input  logic                out_valid,
  input  logic                out_ready,
  input  mips_isa_pkg::word_t result,
  input  logic                branch_taken,
  input  logic                illegal,
  input  mips_isa_pkg::word_t hi,
  input  mips_isa_pkg::word_t lo
);

  // Output register starts empty
  assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // A stalled result must not move
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable(branch_taken)
                                && $stable(illegal) && $stable(hi) && $stable(lo))
    else $error("Output changed while stalled");

  // Execute side keeps its offer until the result register takes it
  assert property (@(posedge clk) disable iff (reset)
    ex_valid && !ex_ready |=> ex_valid && $stable(ex_result) && $stable(ex_branch)
                              && $stable(ex_illegal) && $stable(ex_hi) && $stable(ex_lo))
    else $error("Execute result changed or vanished while ex_ready was low");

endmodule

bind result_stage mips_exec_chk u_chk (
  .clk          (clk),
  .reset        (reset),
  .ex_valid     (ex_valid),
  .ex_ready     (ex_ready),
  .ex_result    (ex_result),
  .ex_branch    (ex_branch),
  .ex_illegal   (ex_illegal),
  .ex_hi        (ex_hi),
  .ex_lo        (ex_lo),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .result       (result),
  .branch_taken (branch_taken),
  .illegal      (illegal),
  .hi           (hi),
  .lo           (lo)
);

// ==== sim/mips_exec_tb.sv ====
`timescale 1ns/1ps

module mips_exec_tb;

  localparam int IN_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 500;

  typedef struct packed {
    mips_isa_pkg::word_t result;
    logic                branch;
    logic                illegal;
    mips_isa_pkg::word_t hi;
    mips_isa_pkg::word_t lo;
    logic [31:0]         acc;      // Edge at which the instruction was accepted
    logic                lat_chk;
  } expect_t;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 in_valid;
  logic                 in_ready;
  mips_isa_pkg::instr_t instr;
  mips_isa_pkg::word_t  rs_value;
  mips_isa_pkg::word_t  rt_value;
  logic                 out_valid;
  logic                 out_ready;
  mips_isa_pkg::word_t  result;
  logic                 branch_taken;
  logic                 illegal;
  mips_isa_pkg::word_t  hi;
  mips_isa_pkg::word_t  lo;

  int                   cycle = 0;
  int                   issued = 0;
  int                   received = 0;
  int                   errors = 0;
  int                   drain_cnt;
  logic                 timed_out = 1'b0;
  logic                 hold_ready = 1'b0;
  mips_isa_pkg::word_t  model_hi = '0;
  mips_isa_pkg::word_t  model_lo = '0;
  expect_t              exp_q[$];
  string                name_q[$];
  expect_t              got_e;
  string                got_name;

  // Mul/div kinds sit at 13..16
  mips_isa_pkg::funct_t rtype_fn [0:16] = '{
    mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR,
    mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA,
    mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV, mips_isa_pkg::FN_SRAV, mips_isa_pkg::FN_SLT,
    mips_isa_pkg::FN_SLTU, mips_isa_pkg::FN_MULT, mips_isa_pkg::FN_MULTU, mips_isa_pkg::FN_DIV,
    mips_isa_pkg::FN_DIVU};
  mips_isa_pkg::opcode_t itype_op [0:16] = '{
    mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI,
    mips_isa_pkg::OP_LUI, mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_BEQ,
    mips_isa_pkg::OP_BNE, mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LW,
    mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU, mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH,
    mips_isa_pkg::OP_SW};
  string kind_name [0:34] = '{
    "addu", "subu", "and", "or", "xor", "sll", "srl", "sra", "sllv", "srlv", "srav", "slt",
    "sltu", "mult", "multu", "div", "divu", "addiu", "andi", "ori", "xori", "lui", "slti",
    "sltiu", "beq", "bne", "lb", "lh", "lw", "lbu", "lhu", "sb", "sh", "sw", "unknown"};

  mips_exec_top dut (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .instr        (instr),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .result       (result),
    .branch_taken (branch_taken),
    .illegal      (illegal),
    .hi           (hi),
    .lo           (lo)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  always @(posedge clk)
  begin
    #2;
    if (hold_ready)
      out_ready = 1'b1;
    else
      out_ready = ($urandom % 4) != 0;  // Stall about a quarter of the cycles
  end

  function automatic mips_isa_pkg::word_t pick_operand();
    case ($urandom % 6)
      0:       return '0;
      1:       return '1;
      2:       return 32'h8000_0000;
      3:       return $urandom % 16;  // Small values for shifts and divides
      default: return $urandom;
    endcase
  endfunction

  function automatic mips_isa_pkg::instr_t build_instr(input int kind);
    mips_isa_pkg::instr_t w;
    w = $urandom;  // Register fields, shamt and immediate stay random
    if (kind < 17)
    begin
      w[31:26] = mips_isa_pkg::OP_RTYPE;
      w[5:0]   = rtype_fn[5'(kind)];
    end
    else if (kind < 34)
    begin
      w[31:26] = itype_op[5'(kind - 17)];
    end
    else
    begin
      case ($urandom % 3)
        0:       w[31:26] = 6'h02;  // J
        1:       w[31:26] = 6'h3f;
        default:
        begin
          w[31:26] = mips_isa_pkg::OP_RTYPE;
          w[5:0]   = 6'h10;  // MFHI is not part of this stage
        end
      endcase
    end
    return w;
  endfunction

  // Expected outputs from the ISA rules, HI/LO tracked in program order
  function automatic expect_t model_instr(input mips_isa_pkg::instr_t w,
                                          input mips_isa_pkg::word_t a,
                                          input mips_isa_pkg::word_t b);
    expect_t             e;
    mips_isa_pkg::word_t simm;
    mips_isa_pkg::word_t zimm;
    logic [63:0]         p;
    logic [63:0]         q;
    logic [63:0]         r;
    longint              sa;
    longint              sb;
    e    = '0;
    simm = {{16{w[15]}}, w[15:0]};
    zimm = {16'h0000, w[15:0]};
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    case (w[31:26])
      mips_isa_pkg::OP_RTYPE:
      begin
        case (w[5:0])
          mips_isa_pkg::FN_ADDU:  e.result = a + b;
          mips_isa_pkg::FN_SUBU:  e.result = a - b;
          mips_isa_pkg::FN_AND:   e.result = a & b;
          mips_isa_pkg::FN_OR:    e.result = a | b;
          mips_isa_pkg::FN_XOR:   e.result = a ^ b;
          mips_isa_pkg::FN_SLL:   e.result = b << w[10:6];
          mips_isa_pkg::FN_SRL:   e.result = b >> w[10:6];
          mips_isa_pkg::FN_SRA:   e.result = $signed(b) >>> w[10:6];
          mips_isa_pkg::FN_SLLV:  e.result = b << a[4:0];
          mips_isa_pkg::FN_SRLV:  e.result = b >> a[4:0];
          mips_isa_pkg::FN_SRAV:  e.result = $signed(b) >>> a[4:0];
          mips_isa_pkg::FN_SLT:   e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mips_isa_pkg::FN_SLTU:  e.result = (a < b) ? 32'd1 : 32'd0;
          mips_isa_pkg::FN_MULT:
          begin
            p        = sa * sb;
            model_hi = p[63:32];
            model_lo = p[31:0];
          end
          mips_isa_pkg::FN_MULTU:
          begin
            p        = {32'h0, a} * {32'h0, b};
            model_hi = p[63:32];
            model_lo = p[31:0];
          end
          mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU:
          begin
            if (b == '0)
            begin
              model_hi = a;   // Divide by zero keeps the dividend
              model_lo = '1;
            end
            else if (w[5:0] == mips_isa_pkg::FN_DIV)
            begin
              q        = sa / sb;  // 64-bit, so the most negative word over -1 is safe
              r        = sa % sb;
              model_hi = r[31:0];
              model_lo = q[31:0];
            end
            else
            begin
              model_hi = a % b;
              model_lo = a / b;
            end
          end
          default: e.illegal = 1'b1;
        endcase
      end
      mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LW,
      mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU, mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH,
      mips_isa_pkg::OP_SW:    e.result = a + simm;
      mips_isa_pkg::OP_ANDI:  e.result = a & zimm;
      mips_isa_pkg::OP_ORI:   e.result = a | zimm;
      mips_isa_pkg::OP_XORI:  e.result = a ^ zimm;
      mips_isa_pkg::OP_LUI:   e.result = {w[15:0], 16'h0000};
      mips_isa_pkg::OP_SLTI:  e.result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      mips_isa_pkg::OP_SLTIU: e.result = (a < simm) ? 32'd1 : 32'd0;
      mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE:
      begin
        e.result = a - b;
        e.branch = (w[31:26] == mips_isa_pkg::OP_BEQ) ? (a == b) : (a != b);
      end
      default: e.illegal = 1'b1;
    endcase
    e.hi = model_hi;
    e.lo = model_lo;
    return e;
  endfunction

  task automatic issue_one();
    int                   kind;
    int                   wait_cnt;
    mips_isa_pkg::instr_t w;
    mips_isa_pkg::word_t  a;
    mips_isa_pkg::word_t  b;
    expect_t              e;
    kind = $urandom % 35;
    w    = build_instr(kind);
    a    = pick_operand();
    b    = pick_operand();
    if (($urandom % 8) == 0)
    begin
      b = a;  // Taken BEQ, equal compares
    end
    e         = model_instr(w, a, b);
    e.lat_chk = hold_ready && !(kind >= 13 && kind <= 16);
    in_valid  = 1'b1;
    instr     = w;
    rs_value  = a;
    rt_value  = b;
    wait_cnt  = 0;
    @(negedge clk);
    while (!in_ready && wait_cnt < IN_TIMEOUT)
    begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!in_ready)
    begin
      timed_out = 1'b1;
      $display("Timeout: in_ready stayed low for %0d cycles on %s", IN_TIMEOUT,
               kind_name[6'(kind)]);
    end
    else
    begin
      e.acc = cycle + 1;  // Transfer happens on the coming edge
      exp_q.push_back(e);
      name_q.push_back(kind_name[6'(kind)]);
      issued++;
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    if (($urandom % 4) == 0)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  // Inputs and outputs are settled at the falling edge
  always @(negedge clk)
  begin
    if (!reset && out_valid && out_ready)
    begin
      received++;
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Output transfer arrived with no instruction outstanding");
      end
      else
      begin
        got_e    = exp_q.pop_front();
        got_name = name_q.pop_front();
        if (result !== got_e.result)
        begin
          errors++;
          $display("Error: %s result expected %h actual %h", got_name, got_e.result, result);
        end
        if (branch_taken !== got_e.branch)
        begin
          errors++;
          $display("Error: %s branch_taken expected %b actual %b", got_name, got_e.branch,
                   branch_taken);
        end
        if (illegal !== got_e.illegal)
        begin
          errors++;
          $display("Error: %s illegal expected %b actual %b", got_name, got_e.illegal, illegal);
        end
        if (hi !== got_e.hi || lo !== got_e.lo)
        begin
          errors++;
          $display("Error: %s hi/lo expected %h/%h actual %h/%h", got_name, got_e.hi,
                   got_e.lo, hi, lo);
        end
        // Decode register then result register, visible after the edge past acceptance
        if (got_e.lat_chk && cycle != got_e.acc + 1)
        begin
          errors++;
          $display("Error: %s output edge expected %0d actual %0d", got_name, got_e.acc + 1,
                   cycle);
        end
      end
    end
  end

  initial
  begin
    void'($urandom(6737));
    reset     = 1'b1;
    in_valid  = 1'b0;
    instr     = '0;
    rs_value  = '0;
    rt_value  = '0;
    out_ready = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    if (in_ready !== 1'b1)
    begin
      errors++;
      $display("Error: in_ready after reset expected 1 actual %b", in_ready);
    end
    for (int i = 0; i < 600 && !timed_out; i++)
    begin
      issue_one();
    end
    hold_ready = 1'b1;  // Steady out_ready for the latency checks
    repeat (2) @(posedge clk);
    #2;
    for (int i = 0; i < 200 && !timed_out; i++)
    begin
      issue_one();
    end
    drain_cnt = 0;
    while (exp_q.size() != 0 && drain_cnt < DRAIN_TIMEOUT)
    begin
      drain_cnt++;
      @(negedge clk);
    end
    if (exp_q.size() != 0)
    begin
      timed_out = 1'b1;
      $display("Timeout: %0d results never came out", exp_q.size());
    end
    repeat (3) @(negedge clk);
    if (received != issued)
    begin
      errors++;
      $display("Error: transfer count expected %0d actual %0d", issued, received);
    end
    $display("Issued %0d, completed %0d, errors %0d", issued, received, errors);
    if (errors == 0 && !timed_out)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== filelist.f ====
common/mips_isa_pkg.sv
common/alu_op_pkg.sv
decode/instr_decode.sv
execute/muldiv_unit.sv
execute/alu_execute.sv
logic/result_stage.sv
logic/mips_exec_top.sv
sim/mips_exec_chk.sv
sim/mips_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module mips_exec_tb -Mdir obj_dir -o mips_exec_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mips_exec_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
